// File: filelist.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
stage_reg.sv
ifu.sv
idu.sv
regfile.sv
exu.sv
core_top.sv
core_asserts.sv
tb_core.sv

// File: Bender.yml
package:
  name: rv32e_core

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - stage_reg.sv
      - ifu.sv
      - idu.sv
      - regfile.sv
      - exu.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_asserts.sv
      - tb_core.sv

// File: tb_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module tb_core
  import isa_pkg::*, pipe_pkg::*;
();

  // One retired instruction with its expected commit
  typedef struct packed {
    logic [31:0]        inst;
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   wdata;
    logic               we;
    logic               illegal;
  } row_t;

  logic             clk;
  logic             rst;
  logic             imem_req;
  logic [`XLEN-1:0] imem_addr;
  logic             imem_rsp;
  logic [31:0]      imem_data;
  logic             commit_valid;
  commit_t          commit;

  row_t        prog[$];
  logic [31:0] imem [64];

  core_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .imem_req_o     (imem_req),
    .imem_addr_o    (imem_addr),
    .imem_rsp_i     (imem_rsp),
    .imem_data_i    (imem_data),
    .commit_valid_o (commit_valid),
    .commit_o       (commit)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] lui_op(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, LUI};
  endfunction

  function automatic logic [31:0] branch_op(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
  endfunction

  function automatic logic [31:0] jal_op(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  // Unused words read back as the inverted address
  function automatic logic [31:0] read_imem(input logic [`XLEN-1:0] addr);
    if (addr < 32'd256)
      return imem[addr[7:2]];
    else
      return ~addr;
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input logic [3:0] rd,
                         input logic [31:0] wdata, input logic we, input logic illegal);
    prog.push_back('{inst, pc, rd, wdata, we, illegal});
  endtask

  // Retirement order, expected values worked out by hand
  task automatic build_program();
    add_row(imm_op(12'd5, 5'd0, F3_ADD, 5'd1), 32'h00, 4'd1, 32'h0000_0005, 1'b1, 1'b0);
    add_row(imm_op(12'hffd, 5'd0, F3_ADD, 5'd2), 32'h04, 4'd2, 32'hffff_fffd, 1'b1, 1'b0);
    add_row(reg_op(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3), 32'h08, 4'd3, 32'h0000_0002, 1'b1, 1'b0);
    add_row(reg_op(F7_SUB, 5'd1, 5'd2, F3_ADD, 5'd4), 32'h0c, 4'd4, 32'hffff_fff8, 1'b1, 1'b0);
    add_row(reg_op(F7_BASE, 5'd4, 5'd2, F3_AND, 5'd5), 32'h10, 4'd5, 32'hffff_fff8, 1'b1, 1'b0);
    add_row(reg_op(F7_BASE, 5'd4, 5'd1, F3_OR, 5'd6), 32'h14, 4'd6, 32'hffff_fffd, 1'b1, 1'b0);
    add_row(reg_op(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd7), 32'h18, 4'd7, 32'hffff_fff8, 1'b1, 1'b0);
    add_row(reg_op(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd8), 32'h1c, 4'd8, 32'h0000_0001, 1'b1, 1'b0);
    add_row(reg_op(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd9), 32'h20, 4'd9, 32'h0000_0000, 1'b1, 1'b0);
    add_row(lui_op(20'h12345, 5'd10), 32'h24, 4'd10, 32'h1234_5000, 1'b1, 1'b0);
    // Write to x0, then read x0 back
    add_row(imm_op(12'd7, 5'd1, F3_ADD, 5'd0), 32'h28, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(reg_op(F7_BASE, 5'd1, 5'd0, F3_ADD, 5'd11), 32'h2c, 4'd11, 32'h5, 1'b1, 1'b0);
    add_row(branch_op(13'd8, 5'd3, 5'd1, F3_BEQ), 32'h30, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(branch_op(13'd8, 5'd3, 5'd1, F3_BNE), 32'h34, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(branch_op(13'd12, 5'd1, 5'd11, F3_BEQ), 32'h3c, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(branch_op(13'd8, 5'd11, 5'd1, F3_BNE), 32'h48, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(jal_op(21'd16, 5'd12), 32'h4c, 4'd12, 32'h0000_0050, 1'b1, 1'b0);
    // ECALL, rd of 16, rs2 of 17
    add_row(32'h0000_0073, 32'h5c, 4'd0, 32'h0, 1'b0, 1'b1);
    add_row(imm_op(12'd1, 5'd1, F3_ADD, 5'd16), 32'h60, 4'd0, 32'h0, 1'b0, 1'b1);
    add_row(reg_op(F7_BASE, 5'd17, 5'd1, F3_ADD, 5'd13), 32'h64, 4'd0, 32'h0, 1'b0, 1'b1);
    add_row(imm_op(12'hffc, 5'd12, F3_ADD, 5'd13), 32'h68, 4'd13, 32'h0000_004c, 1'b1, 1'b0);
    add_row(branch_op(13'd12, 5'd0, 5'd0, F3_BEQ), 32'h6c, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(jal_op(21'h1f_fff8, 5'd14), 32'h78, 4'd14, 32'h0000_007c, 1'b1, 1'b0);
    add_row(imm_op(12'd1, 5'd14, F3_ADD, 5'd15), 32'h70, 4'd15, 32'h0000_007d, 1'b1, 1'b0);
    add_row(jal_op(21'd16, 5'd0), 32'h74, 4'd0, 32'h0, 1'b0, 1'b0);
    add_row(reg_op(F7_SUB, 5'd15, 5'd0, F3_ADD, 5'd15), 32'h84, 4'd15, 32'hffff_ff83, 1'b1, 1'b0);
  endtask

  task automatic load_imem();
    for (int i = 0; i < 64; i++)
    begin
      imem[i] = ~(32'(i) << 2);
    end
    foreach (prog[i])
    begin
      imem[prog[i].pc[7:2]] = prog[i].inst;
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic wait_fetch(input int limit);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!imem_req && cycles < limit);
    assert (imem_req)
    else abort_run("Timed out waiting for the first instruction request after reset");
  endtask

  task automatic wait_commit(input int limit);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!commit_valid && cycles < limit);
    assert (commit_valid)
    else abort_run("Timed out waiting for an instruction to commit");
  endtask

  // Answers each request after 1 to 5 cycles
  initial
  begin : imem_model
    logic [`XLEN-1:0] addr;
    int               lat;
    void'($urandom(32'hd513));
    imem_rsp  = 1'b0;
    imem_data = '0;
    forever
    begin
      @(negedge clk);
      imem_rsp = 1'b0;
      if (!rst && imem_req)
      begin
        addr = imem_addr;
        lat  = ($urandom % 5) + 1;
        repeat (lat) @(negedge clk);
        imem_rsp  = 1'b1;
        imem_data = read_imem(addr);
      end
    end
  end

  initial
  begin : main
    row_t row;
    rst = 1'b1;
    build_program();
    load_imem();
    repeat (10) @(negedge clk);
    rst = 1'b0;

    wait_fetch(20);
    check_field("imem_addr_o", imem_addr, `PC_INIT);

    foreach (prog[i])
    begin
      row = prog[i];
      wait_commit(50);
      check_field($sformatf("commit_o.pc (row %0d)", i), commit.pc, row.pc);
      check_field($sformatf("commit_o.rd (row %0d)", i), 32'(commit.rd), 32'(row.rd));
      check_field($sformatf("commit_o.wdata (row %0d)", i), commit.wdata, row.wdata);
      check_field($sformatf("commit_o.we (row %0d)", i), 32'(commit.we), 32'(row.we));
      check_field($sformatf("commit_o.illegal (row %0d)", i), 32'(commit.illegal),
                  32'(row.illegal));
    end

    if (dut0.asserts0.fail_count != 0)
    begin
      abort_run("A protocol assertion on the core failed during the run");
    end
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module core_asserts
  import pipe_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    imem_req_i,
  input logic    imem_rsp_i,
  input logic    commit_valid_i,
  input commit_t commit_i
);

  int   fail_count = 0;
  logic pending_q;
  logic rst_q;

  // Outstanding request until its response
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pending_q <= 1'b0;
    end
    else if (imem_req_i)
    begin
      pending_q <= 1'b1;
    end
    else if (imem_rsp_i)
    begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    rst_q <= rst;
  end

  a_single_req: assert property (@(posedge clk) disable iff (rst) imem_req_i |-> !pending_q)
  else
  begin
    $error("imem_req_o issued while a request is outstanding");
    fail_count++;
  end

  a_commit_pulse: assert property (@(posedge clk) disable iff (rst)
                                   commit_valid_i |=> !commit_valid_i)
  else
  begin
    $error("commit_valid_o high for more than one cycle");
    fail_count++;
  end

  a_no_req_in_reset: assert property (@(posedge clk) rst && rst_q |-> !imem_req_i)
  else
  begin
    $error("imem_req_o high during reset");
    fail_count++;
  end

  // Illegal no-op never writes
  a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
                                       commit_valid_i && commit_i.illegal |-> !commit_i.we)
  else
  begin
    $error("illegal commit with we set");
    fail_count++;
  end

endmodule

bind core_top core_asserts asserts0 (
  .clk            (clk),
  .rst            (rst),
  .imem_req_i     (imem_req_o),
  .imem_rsp_i     (imem_rsp_i),
  .commit_valid_i (commit_valid_o),
  .commit_i       (commit_o)
);

`default_nettype wire

// File: core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module core_top
  import pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output logic             imem_req_o,
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic             imem_rsp_i,
  input  logic [31:0]      imem_data_i,
  output logic             commit_valid_o,
  output commit_t          commit_o
);

  logic               fetch_valid;
  logic               fetch_ready;
  fetch_pkt_t         fetch_pkt;
  logic               exec_valid;
  logic               exec_ready;
  exec_pkt_t          exec_pkt;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [`XLEN-1:0]   rdata1;
  logic [`XLEN-1:0]   rdata2;
  logic               commit_valid;
  commit_t            commit;
  logic [`XLEN-1:0]   npc;

  ifu ifu0 (
    .clk         (clk),
    .rst         (rst),
    .imem_req_o  (imem_req_o),
    .imem_addr_o (imem_addr_o),
    .imem_rsp_i  (imem_rsp_i),
    .imem_data_i (imem_data_i),
    .commit_i    (commit_valid),
    .npc_i       (npc),
    .valid_o     (fetch_valid),
    .pkt_o       (fetch_pkt),
    .ready_i     (fetch_ready)
  );

  idu idu0 (
    .clk      (clk),
    .rst      (rst),
    .valid_i  (fetch_valid),
    .pkt_i    (fetch_pkt),
    .ready_o  (fetch_ready),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .valid_o  (exec_valid),
    .pkt_o    (exec_pkt),
    .ready_i  (exec_ready)
  );

  // Written at commit
  regfile regfile0 (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (commit_valid & commit.we),
    .rd_i     (commit.rd),
    .wdata_i  (commit.wdata)
  );

  exu exu0 (
    .clk            (clk),
    .rst            (rst),
    .valid_i        (exec_valid),
    .pkt_i          (exec_pkt),
    .ready_o        (exec_ready),
    .commit_valid_o (commit_valid),
    .commit_o       (commit),
    .npc_o          (npc)
  );

  assign commit_valid_o = commit_valid;
  assign commit_o       = commit;

endmodule

`default_nettype wire

// File: exu.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module exu
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             valid_i,
  input  exec_pkt_t        pkt_i,
  output logic             ready_o,
  output logic             commit_valid_o,
  output commit_t          commit_o,
  output logic [`XLEN-1:0] npc_o
);

  logic             commit_valid_q;
  commit_t          commit_q;
  logic [`XLEN-1:0] npc_q;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] target;
  logic             taken;
  logic             we;
  logic             accept;

  always_comb
  begin
    case (pkt_i.alu_op)
      ALU_SUB:    alu_res = pkt_i.op_a - pkt_i.op_b;
      ALU_AND:    alu_res = pkt_i.op_a & pkt_i.op_b;
      ALU_OR:     alu_res = pkt_i.op_a | pkt_i.op_b;
      ALU_XOR:    alu_res = pkt_i.op_a ^ pkt_i.op_b;
      ALU_SLT:    alu_res = {31'b0, $signed(pkt_i.op_a) < $signed(pkt_i.op_b)};
      ALU_PASS_B: alu_res = pkt_i.op_b;
      default:    alu_res = pkt_i.op_a + pkt_i.op_b;
    endcase
  end

  assign link   = pkt_i.pc + 32'd4;
  assign target = pkt_i.pc + pkt_i.imm;
  assign taken  = pkt_i.is_branch & ((pkt_i.op_a == pkt_i.op_b) ^ pkt_i.branch_ne);
  // Writes to x0 retire without a write
  assign we     = pkt_i.rd_we & (pkt_i.rd != '0);

  assign ready_o = ~commit_valid_q;
  assign accept  = valid_i & ready_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      commit_valid_q <= 1'b0;
    end
    else
    begin
      commit_valid_q <= accept;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      commit_q.pc      <= pkt_i.pc;
      commit_q.rd      <= pkt_i.rd;
      commit_q.wdata   <= we ? (pkt_i.is_jump ? link : alu_res) : '0;
      commit_q.we      <= we;
      commit_q.illegal <= pkt_i.illegal;
      npc_q            <= (pkt_i.is_jump || taken) ? target : link;
    end
  end

  assign commit_valid_o = commit_valid_q;
  assign commit_o       = commit_q;
  assign npc_o          = npc_q;

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module regfile (
  input  logic               clk,
  input  logic               rst,
  input  logic [`REG_AW-1:0] rs1_i,
  input  logic [`REG_AW-1:0] rs2_i,
  output logic [`XLEN-1:0]   rdata1_o,
  output logic [`XLEN-1:0]   rdata2_o,
  input  logic               we_i,
  input  logic [`REG_AW-1:0] rd_i,
  input  logic [`XLEN-1:0]   wdata_i
);

  logic [`XLEN-1:0] rf [`REG_NUM];

  assign rdata1_o = rf[rs1_i];
  assign rdata2_o = rf[rs2_i];

  for (genvar g = 0; g < `REG_NUM; g++)
  begin : g_entry
    localparam logic [`REG_AW-1:0] IDX = g;

    // x0 is cleared by reset and never written
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        rf[g] <= '0;
      end
      else if (we_i && rd_i == IDX && IDX != '0)
      begin
        rf[g] <= wdata_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: idu.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module idu
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               valid_i,
  input  fetch_pkt_t         pkt_i,
  output logic               ready_o,
  output logic [`REG_AW-1:0] rs1_o,
  output logic [`REG_AW-1:0] rs2_o,
  input  logic [`XLEN-1:0]   rdata1_i,
  input  logic [`XLEN-1:0]   rdata2_i,
  output logic               valid_o,
  output exec_pkt_t          pkt_o,
  input  logic               ready_i
);

  logic [31:0]      inst;
  logic [6:0]       opcode;
  logic [6:0]       funct7;
  logic [2:0]       funct3;
  logic [4:0]       rd_f;
  logic [4:0]       rs1_f;
  logic [4:0]       rs2_f;
  logic             use_rs1;
  logic             use_rs2;
  logic             bad_reg;
  dec_op_t          dec;
  logic [`XLEN-1:0] imm;
  exec_pkt_t        exec_pkt;

  function automatic alu_op_e alu_of(input logic [2:0] f3);
    case (f3)
      F3_SLT:  return ALU_SLT;
      F3_XOR:  return ALU_XOR;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign inst   = pkt_i.inst;
  assign opcode = inst[6:0];
  assign rd_f   = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1_f  = inst[19:15];
  assign rs2_f  = inst[24:20];
  assign funct7 = inst[31:25];

  assign rs1_o = rs1_f[`REG_AW-1:0];
  assign rs2_o = rs2_f[`REG_AW-1:0];

  always_comb
  begin
    dec.alu_op    = ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.rd_we     = 1'b0;
    dec.is_branch = 1'b0;
    dec.branch_ne = 1'b0;
    dec.is_jump   = 1'b0;
    dec.illegal   = 1'b0;
    use_rs1       = 1'b0;
    use_rs2       = 1'b0;
    case (opcode)
      OP_IMM:
      begin
        use_rs1     = 1'b1;
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
        dec.alu_op  = alu_of(funct3);
        dec.illegal = !(funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND});
      end
      OP:
      begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        dec.rd_we   = 1'b1;
        dec.alu_op  = (funct7 == F7_SUB) ? ALU_SUB : alu_of(funct3);
        dec.illegal = !((funct7 == F7_BASE &&
                         funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND}) ||
                        (funct7 == F7_SUB && funct3 == F3_ADD));
      end
      LUI:
      begin
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
        dec.alu_op  = ALU_PASS_B;
      end
      JAL:
      begin
        dec.rd_we   = 1'b1;
        dec.is_jump = 1'b1;
      end
      BRANCH:
      begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        dec.is_branch = 1'b1;
        dec.branch_ne = (funct3 == F3_BNE);
        dec.illegal   = !(funct3 inside {F3_BEQ, F3_BNE});
      end
      default: dec.illegal = 1'b1;
    endcase
    // RV32E has no x16..x31
    bad_reg = (use_rs1 & rs1_f[4]) | (use_rs2 & rs2_f[4]) | (dec.rd_we & rd_f[4]);
    if (dec.illegal || bad_reg)
    begin
      dec.illegal   = 1'b1;
      dec.rd_we     = 1'b0;
      dec.is_branch = 1'b0;
      dec.is_jump   = 1'b0;
    end
  end

  always_comb
  begin
    case (opcode)
      LUI:     imm = {inst[31:12], 12'b0};
      JAL:     imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      BRANCH:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      default: imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

  assign exec_pkt.pc        = pkt_i.pc;
  assign exec_pkt.op_a      = rdata1_i;
  assign exec_pkt.op_b      = dec.use_imm ? imm : rdata2_i;
  assign exec_pkt.imm       = imm;
  assign exec_pkt.alu_op    = dec.alu_op;
  assign exec_pkt.rd        = dec.rd_we ? rd_f[`REG_AW-1:0] : '0;
  assign exec_pkt.rd_we     = dec.rd_we;
  assign exec_pkt.is_branch = dec.is_branch;
  assign exec_pkt.branch_ne = dec.branch_ne;
  assign exec_pkt.is_jump   = dec.is_jump;
  assign exec_pkt.illegal   = dec.illegal;

  stage_reg #(.payload_t(exec_pkt_t)) decode_q (
    .clk     (clk),
    .rst     (rst),
    .valid_i (valid_i),
    .data_i  (exec_pkt),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .data_o  (pkt_o),
    .ready_i (ready_i)
  );

endmodule

`default_nettype wire

// File: ifu.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module ifu
  import pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output logic             imem_req_o,
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic             imem_rsp_i,
  input  logic [31:0]      imem_data_i,
  input  logic             commit_i,
  input  logic [`XLEN-1:0] npc_i,
  output logic             valid_o,
  output fetch_pkt_t       pkt_o,
  input  logic             ready_i
);

  logic [`XLEN-1:0] pc_q;
  logic             req_q;
  logic             boot_q;
  fetch_pkt_t       rsp_pkt;

  // One request after reset, then one per commit
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q   <= `PC_INIT;
      req_q  <= 1'b0;
      boot_q <= 1'b1;
    end
    else
    begin
      boot_q <= 1'b0;
      req_q  <= boot_q | commit_i;
      if (commit_i)
      begin
        pc_q <= npc_i;
      end
    end
  end

  assign imem_req_o  = req_q;
  assign imem_addr_o = pc_q;

  assign rsp_pkt.pc   = pc_q;
  assign rsp_pkt.inst = imem_data_i;

  stage_reg #(.payload_t(fetch_pkt_t)) fetch_q (
    .clk     (clk),
    .rst     (rst),
    .valid_i (imem_rsp_i),
    .data_i  (rsp_pkt),
    .ready_o (),
    .valid_o (valid_o),
    .data_o  (pkt_o),
    .ready_i (ready_i)
  );

endmodule

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Takes a new item only when empty
  assign ready_o = ~valid_q;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else if (valid_i && ready_o)
    begin
      valid_q <= 1'b1;
    end
    else if (valid_q && ready_i)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (valid_i && ready_o)
    begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

`include "core_defs.svh"

package pipe_pkg;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
  } fetch_pkt_t;

  // Operands and control handed from decode to execute
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   imm;
    isa_pkg::alu_op_e   alu_op;
    logic [`REG_AW-1:0] rd;
    logic               rd_we;
    logic               is_branch;
    logic               branch_ne;
    logic               is_jump;
    logic               illegal;
  } exec_pkt_t;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   wdata;
    logic               we;
    logic               illegal;
  } commit_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011
  } opcode_e;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    rd_we;
    logic    is_branch;
    logic    branch_ne;
    logic    is_jump;
    logic    illegal;
  } dec_op_t;

endpackage

`default_nettype wire

// File: core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define XLEN 32

// RV32E register file
`define REG_NUM 16
`define REG_AW 4

`define PC_INIT 32'h0000_0000

`endif
